// ==== verif/mfp_trace.txt ====
# columns: op, first value, second value, all hex (unused value is 00)
# W addr data, R addr expected, SP byte, SO expected byte, AK vector, IRQ/FULL level, PIN pins, T timer, N cycles
# register read back, gpip mixes pins and latch
W 01 a5
R 01 a5
W 01 00
W 02 0f
W 00 a5
R 00 f5
W 0b 40
R 0b 40
W 09 80
R 09 80
W 0a 01
R 0a 01
W 03 80
R 03 80
W 04 01
R 04 01
# pins 0 and 7 fall together, highest is served first
PIN 7e 00
N 05 00
IRQ 01 00
AK 4f 00
IRQ 01 00
AK 40 00
IRQ 00 00
R 05 00
R 06 00
PIN ff 00
# in-service mode blocks lower levels
W 0b 48
PIN 7f 00
N 05 00
IRQ 01 00
AK 4f 00
IRQ 00 00
R 07 80
PIN ff 00
PIN fe 00
N 05 00
IRQ 00 00
R 06 01
W 07 00
IRQ 01 00
AK 40 00
IRQ 00 00
W 08 00
# aer bit 0 turns a rising pin into an interrupt
W 01 01
N 03 00
PIN ff 00
N 05 00
IRQ 01 00
R 06 01
W 06 00
IRQ 00 00
W 01 00
# timer a, delay mode 1, data 5
W 03 20
W 0f 05
W 0c 01
R 0c 01
N 19 00
R 05 20
W 0c 00
W 05 00
R 05 00
# timer b, event mode, data 3
W 03 01
W 10 03
W 0d 08
R 0d 08
T 01 00
T 01 00
R 10 01
T 01 00
N 02 00
R 05 01
R 10 03
W 0d 00
W 05 00
# output fifo
W 03 04
W 17 11
W 17 22
W 17 33
W 17 44
R 16 00
SO 11 00
N 01 00
R 05 04
SO 22 00
SO 33 00
SO 44 00
R 16 80
W 05 00
# input fifo
W 03 10
R 15 00
SP 55 00
SP 66 00
SP 77 00
FULL 00 00
R 15 80
R 05 10
SP 88 00
FULL 01 00
R 17 55
FULL 00 00
R 17 66
R 17 77
R 17 88
R 15 00
# disabling in ier drops the request
W 09 10
IRQ 01 00
W 03 00
IRQ 00 00
R 05 00

// ==== tb.f ====
hw/mfp_pkg.sv
hw/mfp_prio.sv
hw/mfp_timer.sv
hw/io_fifo.sv
hw/mfp_regs.sv
hw/mfp.sv
verif/mfp_asserts.sv
verif/tb_mfp.sv

// ==== verif/tb_mfp.sv ====
// ================================================
// trace driven testbench for the mfp peripheral
// ================================================
module tb_mfp;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH   = 4;
	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 8;
	// extra cycles on top of what the trace asks for
	localparam int SLACK_CYCLES = 200;
	localparam TRACE_FILE = "verif/mfp_trace.txt";

	// trace operation codes
	localparam int OP_WRITE = 1;
	localparam int OP_READ  = 2;
	localparam int OP_PUSH  = 3;
	localparam int OP_POP   = 4;
	localparam int OP_IACK  = 5;
	localparam int OP_IRQ   = 6;
	localparam int OP_PINS  = 7;
	localparam int OP_TIMER = 8;
	localparam int OP_WAIT  = 9;
	localparam int OP_FULL  = 10;

	logic       clk;
	logic       reset;
	logic       sel;
	logic       ds;
	logic       rw;
	logic [4:0] addr;
	logic [7:0] din;
	logic [7:0] dout;
	logic       irq;
	logic       iack;
	logic [7:0] gpio;
	logic [1:0] t_in;
	logic       strobe_out;
	logic [7:0] data_out;
	logic       data_out_avail;
	logic       strobe_in;
	logic [7:0] data_in;
	logic       data_in_full;

	// trace contents, one entry per operation
	int          op_q[$];
	logic [31:0] arg_a_q[$];
	logic [31:0] arg_b_q[$];
	int          err_cnt;
	int          check_cnt;
	int          cycle_cnt;
	int          cycle_limit;
	bit          trace_ok;

	mfp #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (
		.clk                         (clk),
		.reset                       (reset),
		.sel_i                       (sel),
		.ds_i                        (ds),
		.rw_i                        (rw),
		.addr_i                      (addr),
		.din_i                       (din),
		.dout_o                      (dout),
		.irq_o                       (irq),
		.iack_i                      (iack),
		.gpio_i                      (gpio),
		.t_i                         (t_in),
		.serial_strobe_out_i         (strobe_out),
		.serial_data_out_o           (data_out),
		.serial_data_out_available_o (data_out_avail),
		.serial_strobe_in_i          (strobe_in),
		.serial_data_in_i            (data_in),
		.serial_data_in_full_o       (data_in_full)
	);

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	// watchdog, limit is known once the trace is loaded
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic int op_code(input logic [63:0] tok);
		case (tok)
			"W":     op_code = OP_WRITE;
			"R":     op_code = OP_READ;
			"SP":    op_code = OP_PUSH;
			"SO":    op_code = OP_POP;
			"AK":    op_code = OP_IACK;
			"IRQ":   op_code = OP_IRQ;
			"PIN":   op_code = OP_PINS;
			"T":     op_code = OP_TIMER;
			"N":     op_code = OP_WAIT;
			"FULL":  op_code = OP_FULL;
			default: op_code = 0;
		endcase
	endfunction

	// clock cycles one operation takes
	function automatic int op_cycles(input int code, input logic [31:0] a);
		if (code == OP_WAIT)
			op_cycles = int'(a);
		else if (code == OP_TIMER)
			op_cycles = 2;
		else
			op_cycles = 1;
	endfunction

	task automatic load_trace(output bit ok);
		int                 fd;
		int                 rc;
		int                 code;
		int                 total;
		logic [63:0]        tok;
		logic [31:0]        a;
		logic [31:0]        b;
		logic [8*256-1:0]   rest;
		ok = 1'b0;
		total = RESET_CYCLES;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the trace file %0s", TRACE_FILE);
		end else begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				tok = '0;
				rc = $fscanf(fd, "%s", tok);
				if (rc == 1) begin
					// comment lines start with a lone hash
					if (tok == "#") begin
						rc = $fgets(rest, fd);
					end else begin
						code = op_code(tok);
						rc = $fscanf(fd, "%h %h", a, b);
						if (code == 0 || rc != 2) begin
							$display("trace line starting with %0s cannot be read", tok);
							ok = 1'b0;
						end else begin
							op_q.push_back(code);
							arg_a_q.push_back(a);
							arg_b_q.push_back(b);
							total += op_cycles(code, a);
						end
					end
				end
			end
			$fclose(fd);
			if (op_q.size() == 0) begin
				$display("the trace file holds no operations");
				ok = 1'b0;
			end
			cycle_limit = total + SLACK_CYCLES;
		end
	endtask

	// idle bus, all strobes inactive
	task automatic release_bus();
		sel        = 1'b0;
		ds         = 1'b1;
		rw         = 1'b1;
		addr       = 5'd0;
		din        = 8'd0;
		iack       = 1'b0;
		strobe_out = 1'b0;
		strobe_in  = 1'b0;
		data_in    = 8'd0;
	endtask

	// each access starts at a falling edge and lasts one cycle
	task automatic write_reg(input logic [4:0] a, input logic [7:0] data);
		sel  = 1'b1;
		ds   = 1'b0;
		rw   = 1'b0;
		addr = a;
		din  = data;
		@(posedge clk);
		@(negedge clk);
		release_bus();
	endtask

	task automatic read_reg(input logic [4:0] a, input logic [7:0] exp);
		sel  = 1'b1;
		ds   = 1'b0;
		rw   = 1'b1;
		addr = a;
		@(posedge clk);
		check_cnt++;
		if (dout !== exp) begin
			err_cnt++;
			$display("error %0t: register %h read %h, expected %h", $time, a, dout, exp);
		end
		@(negedge clk);
		release_bus();
	endtask

	task automatic push_serial(input logic [7:0] data);
		strobe_in = 1'b1;
		data_in   = data;
		@(posedge clk);
		@(negedge clk);
		release_bus();
	endtask

	task automatic pop_serial(input logic [7:0] exp);
		strobe_out = 1'b1;
		@(posedge clk);
		check_cnt++;
		if (data_out_avail !== 1'b1) begin
			err_cnt++;
			$display("error %0t: serial pop with no data available", $time);
		end
		if (data_out !== exp) begin
			err_cnt++;
			$display("error %0t: serial pop gave %h, expected %h", $time, data_out, exp);
		end
		@(negedge clk);
		release_bus();
	endtask

	// vector is the one held from the cycle before
	task automatic acknowledge(input logic [7:0] exp);
		iack = 1'b1;
		@(posedge clk);
		check_cnt++;
		if (dout !== exp) begin
			err_cnt++;
			$display("error %0t: acknowledge vector %h, expected %h", $time, dout, exp);
		end
		@(negedge clk);
		release_bus();
	endtask

	task automatic check_irq(input logic exp);
		@(posedge clk);
		check_cnt++;
		if (irq !== exp) begin
			err_cnt++;
			$display("error %0t: irq_o is %b, expected %b", $time, irq, exp);
		end
		@(negedge clk);
	endtask

	task automatic check_full(input logic exp);
		@(posedge clk);
		check_cnt++;
		if (data_in_full !== exp) begin
			err_cnt++;
			$display("error %0t: input fifo full is %b, expected %b", $time, data_in_full, exp);
		end
		@(negedge clk);
	endtask

	task automatic set_pins(input logic [7:0] pins);
		gpio = pins;
		@(negedge clk);
	endtask

	task automatic pulse_timer_in(input logic idx);
		t_in[idx] = 1'b1;
		@(negedge clk);
		t_in[idx] = 1'b0;
		@(negedge clk);
	endtask

	task automatic run_op(input int code, input logic [31:0] a, input logic [31:0] b);
		case (code)
			OP_WRITE: write_reg(a[4:0], b[7:0]);
			OP_READ:  read_reg(a[4:0], b[7:0]);
			OP_PUSH:  push_serial(a[7:0]);
			OP_POP:   pop_serial(a[7:0]);
			OP_IACK:  acknowledge(a[7:0]);
			OP_IRQ:   check_irq(a[0]);
			OP_PINS:  set_pins(a[7:0]);
			OP_TIMER: pulse_timer_in(a[0]);
			OP_WAIT:  repeat (int'(a)) @(negedge clk);
			OP_FULL:  check_full(a[0]);
			default: ;
		endcase
	endtask

	initial begin
		err_cnt     = 0;
		check_cnt   = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		reset       = 1'b1;
		// pins idle high, so a falling pin is an active edge
		gpio        = 8'hff;
		t_in        = 2'b00;
		release_bus();
		load_trace(trace_ok);
		if (!trace_ok) begin
			$display("trace file missing or unreadable, no test was run");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(negedge clk);
			reset = 1'b0;
			for (int i = 0; i < op_q.size(); i++)
				run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
			$display("%0d checks done, %0d errors", check_cnt, err_cnt);
			if (err_cnt == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

// ==== verif/mfp_asserts.sv ====
// ================================================
// bound checks on irq, read mux and tx fifo flag
// ================================================
module mfp_asserts (
	input logic       clk,
	input logic       reset,
	input logic       sel_i,
	input logic       ds_i,
	input logic       rw_i,
	input logic       iack_i,
	input logic [7:0] dout_i,
	input logic       irq_i,
	input logic       tx_push_i,
	input logic       out_avail_i
);

	timeunit 1ns;
	timeprecision 1ps;

	logic bus_rd;

	assign bus_rd = sel_i && !ds_i && rw_i;

	// registers hold their reset values from the second reset cycle on
	irq_low_in_reset: assert property (
		@(posedge clk) reset && $past(reset) |-> !irq_i
	) else $error("irq_o high while reset is asserted");

	// idle bus drives zero
	dout_idle_zero: assert property (
		@(posedge clk) disable iff (reset)
		!bus_rd && !iack_i |-> dout_i == 8'd0
	) else $error("dout_o not zero without read or acknowledge");

	// a pushed byte is visible one cycle later
	avail_after_push: assert property (
		@(posedge clk) disable iff (reset)
		tx_push_i |=> out_avail_i
	) else $error("output fifo shows no data after a push");

endmodule

bind mfp mfp_asserts u_asserts (
	.clk         (clk),
	.reset       (reset),
	.sel_i       (sel_i),
	.ds_i        (ds_i),
	.rw_i        (rw_i),
	.iack_i      (iack_i),
	.dout_i      (dout_o),
	.irq_i       (irq_o),
	.tx_push_i   (tx_push),
	.out_avail_i (serial_data_out_available_o)
);

// ==== hw/mfp.sv ====
// ================================================
// mfp top, control block with timers and fifos
// ================================================
module mfp import mfp_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
	input  logic       clk,
	input  logic       reset,
	// cpu bus
	input  logic       sel_i,
	input  logic       ds_i,
	input  logic       rw_i,
	input  mfp_addr_t  addr_i,
	input  logic [7:0] din_i,
	output logic [7:0] dout_o,
	output logic       irq_o,
	input  logic       iack_i,
	// pins and timer inputs
	input  logic [7:0] gpio_i,
	input  logic [1:0] t_i,
	// io controller side
	input  logic       serial_strobe_out_i,
	output logic [7:0] serial_data_out_o,
	output logic       serial_data_out_available_o,
	input  logic       serial_strobe_in_i,
	input  logic [7:0] serial_data_in_i,
	output logic       serial_data_in_full_o
);

	logic       ta_ctrl_we;
	logic       ta_dat_we;
	logic [7:0] ta_dat;
	logic [3:0] ta_ctrl;
	logic       ta_done;
	logic       tb_ctrl_we;
	logic       tb_dat_we;
	logic [7:0] tb_dat;
	logic [3:0] tb_ctrl;
	logic       tb_done;
	logic       tx_push;
	logic       tx_full;
	logic       rx_pop;
	logic [7:0] rx_data;
	logic       rx_avail;

	mfp_regs u_regs (
		.clk          (clk),
		.reset        (reset),
		.sel_i        (sel_i),
		.ds_i         (ds_i),
		.rw_i         (rw_i),
		.addr_i       (addr_i),
		.din_i        (din_i),
		.dout_o       (dout_o),
		.irq_o        (irq_o),
		.iack_i       (iack_i),
		.gpio_i       (gpio_i),
		.ta_ctrl_we_o (ta_ctrl_we),
		.ta_dat_we_o  (ta_dat_we),
		.ta_dat_i     (ta_dat),
		.ta_ctrl_i    (ta_ctrl),
		.ta_done_i    (ta_done),
		.tb_ctrl_we_o (tb_ctrl_we),
		.tb_dat_we_o  (tb_dat_we),
		.tb_dat_i     (tb_dat),
		.tb_ctrl_i    (tb_ctrl),
		.tb_done_i    (tb_done),
		.tx_push_o    (tx_push),
		.tx_full_i    (tx_full),
		.rx_pop_o     (rx_pop),
		.rx_data_i    (rx_data),
		.rx_avail_i   (rx_avail)
	);

	// timer a counts events on t_i[0], timer b on t_i[1]
	mfp_timer timer_a (
		.clk       (clk),
		.reset     (reset),
		.ctrl_we_i (ta_ctrl_we),
		.dat_we_i  (ta_dat_we),
		.din_i     (din_i),
		.t_i       (t_i[0]),
		.dat_o     (ta_dat),
		.ctrl_o    (ta_ctrl),
		.done_o    (ta_done)
	);

	mfp_timer timer_b (
		.clk       (clk),
		.reset     (reset),
		.ctrl_we_i (tb_ctrl_we),
		.dat_we_i  (tb_dat_we),
		.din_i     (din_i),
		.t_i       (t_i[1]),
		.dat_o     (tb_dat),
		.ctrl_o    (tb_ctrl),
		.done_o    (tb_done)
	);

	// cpu writes udr, io controller drains
	io_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
		.clk     (clk),
		.reset   (reset),
		.push_i  (tx_push),
		.din_i   (din_i),
		.pop_i   (serial_strobe_out_i),
		.dout_o  (serial_data_out_o),
		.full_o  (tx_full),
		.avail_o (serial_data_out_available_o)
	);

	// io controller fills, cpu reads udr
	io_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
		.clk     (clk),
		.reset   (reset),
		.push_i  (serial_strobe_in_i),
		.din_i   (serial_data_in_i),
		.pop_i   (rx_pop),
		.dout_o  (rx_data),
		.full_o  (serial_data_in_full_o),
		.avail_o (rx_avail)
	);

endmodule

// ==== hw/mfp_regs.sv ====
// ================================================
// cpu registers, interrupt controller, edge logic
// and read mux of the mfp
// ================================================
module mfp_regs import mfp_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       sel_i,
	input  logic       ds_i,
	input  logic       rw_i,
	input  mfp_addr_t  addr_i,
	input  logic [7:0] din_i,
	output logic [7:0] dout_o,
	output logic       irq_o,
	input  logic       iack_i,
	input  logic [7:0] gpio_i,
	// timer a
	output logic       ta_ctrl_we_o,
	output logic       ta_dat_we_o,
	input  logic [7:0] ta_dat_i,
	input  logic [3:0] ta_ctrl_i,
	input  logic       ta_done_i,
	// timer b
	output logic       tb_ctrl_we_o,
	output logic       tb_dat_we_o,
	input  logic [7:0] tb_dat_i,
	input  logic [3:0] tb_ctrl_i,
	input  logic       tb_done_i,
	// fifos
	output logic       tx_push_o,
	input  logic       tx_full_i,
	output logic       rx_pop_o,
	input  logic [7:0] rx_data_i,
	input  logic       rx_avail_i
);

	logic [7:0]  gpip;
	logic [7:0]  aer;
	logic [7:0]  ddr;
	logic [15:0] ier;
	logic [15:0] ipr;
	logic [15:0] imr;
	logic [15:0] isr;
	logic [7:0]  vr;
	// usart control bits, stored only
	logic [1:0]  rx_ctrl;
	logic [3:0]  tx_ctrl;
	// pin edge pipeline after aer
	logic [7:0]  edge_d1;
	logic [7:0]  edge_d2;
	logic        tx_nf_q;
	logic        rx_av_q;
	logic        iack_q;
	// vector frozen while iack is high
	logic [7:0]  irq_vec;
	logic [15:0] pend_map;
	logic [3:0]  pend_num;
	logic        pend_any;
	logic [3:0]  isr_num;
	logic        wr;
	logic        rd;

	assign wr = sel_i && !ds_i && !rw_i;
	assign rd = sel_i && !ds_i && rw_i;

	// strobes to the datapath blocks
	assign ta_ctrl_we_o = wr && (addr_i == ADDR_TACR);
	assign tb_ctrl_we_o = wr && (addr_i == ADDR_TBCR);
	assign ta_dat_we_o  = wr && (addr_i == ADDR_TADR);
	assign tb_dat_we_o  = wr && (addr_i == ADDR_TBDR);
	assign tx_push_o    = wr && (addr_i == ADDR_UDR);
	assign rx_pop_o     = rd && (addr_i == ADDR_UDR);

	assign pend_map = ipr & imr;

	mfp_prio u_pend_prio (
		.map_i (pend_map),
		.num_o (pend_num),
		.any_o (pend_any)
	);

	// empty isr yields 0, same as in-service level 0
	mfp_prio u_isr_prio (
		.map_i (isr),
		.num_o (isr_num),
		.any_o ()
	);

	// request only at or above the level in service
	assign irq_o = pend_any && (pend_num >= isr_num);

	always_ff @(posedge clk) begin
		if (!iack_i)
			irq_vec <= {vr[7:4], pend_num};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			gpip    <= 8'd0;
			aer     <= 8'd0;
			ddr     <= 8'd0;
			ier     <= 16'd0;
			ipr     <= 16'd0;
			imr     <= 16'd0;
			isr     <= 16'd0;
			vr      <= 8'd0;
			rx_ctrl <= 2'd0;
			tx_ctrl <= 4'd0;
			edge_d1 <= 8'd0;
			edge_d2 <= 8'd0;
			tx_nf_q <= 1'b0;
			rx_av_q <= 1'b0;
			iack_q  <= 1'b0;
		end else begin
			edge_d1 <= gpio_i ^ aer;
			edge_d2 <= edge_d1;
			tx_nf_q <= !tx_full_i;
			rx_av_q <= rx_avail_i;
			iack_q  <= iack_i;

			// first cycle of acknowledge, move the winner out of ipr
			if (iack_i && !iack_q) begin
				ipr[pend_num] <= 1'b0;
				// software end of interrupt mode
				if (vr[3])
					isr[pend_num] <= 1'b1;
			end

			if (ta_done_i && ier[IRQ_TIMER_A])
				ipr[IRQ_TIMER_A] <= 1'b1;
			if (tb_done_i && ier[IRQ_TIMER_B])
				ipr[IRQ_TIMER_B] <= 1'b1;

			// falling edge after aer, so aer=1 catches rising pins
			for (int i = 0; i < 8; i++) begin
				if (edge_d2[i] && !edge_d1[i] && ier[GPIP_IRQ_MAP[i]])
					ipr[GPIP_IRQ_MAP[i]] <= 1'b1;
			end

			// tx fifo has room again, rx fifo got data
			if (!tx_nf_q && !tx_full_i && ier[IRQ_TX_EMPTY])
				ipr[IRQ_TX_EMPTY] <= 1'b1;
			if (!rx_av_q && rx_avail_i && ier[IRQ_RX_FULL])
				ipr[IRQ_RX_FULL] <= 1'b1;

			// bus writes come last and override the sources
			if (wr) begin
				case (addr_i)
					ADDR_GPIP: gpip <= din_i;
					ADDR_AER:  aer  <= din_i;
					ADDR_DDR:  ddr  <= din_i;
					ADDR_IERA: begin
						ier[15:8] <= din_i;
						ipr[15:8] <= ipr[15:8] & din_i;
					end
					ADDR_IERB: begin
						ier[7:0] <= din_i;
						ipr[7:0] <= ipr[7:0] & din_i;
					end
					// zero bits clear, one bits keep
					ADDR_IPRA: ipr[15:8] <= ipr[15:8] & din_i;
					ADDR_IPRB: ipr[7:0]  <= ipr[7:0] & din_i;
					ADDR_ISRA: isr[15:8] <= isr[15:8] & din_i;
					ADDR_ISRB: isr[7:0]  <= isr[7:0] & din_i;
					ADDR_IMRA: imr[15:8] <= din_i;
					ADDR_IMRB: imr[7:0]  <= din_i;
					ADDR_VR:   vr        <= din_i;
					ADDR_RSR:  rx_ctrl   <= din_i[1:0];
					ADDR_TSR:  tx_ctrl   <= din_i[3:0];
					default: ;
				endcase
			end
		end
	end

	// read mux, vector output during acknowledge
	always_comb begin
		dout_o = 8'd0;
		if (rd) begin
			case (addr_i)
				// ddr bit set means pin is an output
				ADDR_GPIP: dout_o = (gpio_i & ~ddr) | (gpip & ddr);
				ADDR_AER:  dout_o = aer;
				ADDR_DDR:  dout_o = ddr;
				ADDR_IERA: dout_o = ier[15:8];
				ADDR_IERB: dout_o = ier[7:0];
				ADDR_IPRA: dout_o = ipr[15:8];
				ADDR_IPRB: dout_o = ipr[7:0];
				ADDR_ISRA: dout_o = isr[15:8];
				ADDR_ISRB: dout_o = isr[7:0];
				ADDR_IMRA: dout_o = imr[15:8];
				ADDR_IMRB: dout_o = imr[7:0];
				ADDR_VR:   dout_o = vr;
				ADDR_TACR: dout_o = {4'd0, ta_ctrl_i};
				ADDR_TBCR: dout_o = {4'd0, tb_ctrl_i};
				ADDR_TADR: dout_o = ta_dat_i;
				ADDR_TBDR: dout_o = tb_dat_i;
				ADDR_RSR:  dout_o = {rx_avail_i, 5'd0, rx_ctrl};
				// buffer empty bit reads as "fifo not full"
				ADDR_TSR:  dout_o = {!tx_full_i, 3'd0, tx_ctrl};
				ADDR_UDR:  dout_o = rx_data_i;
				default:   dout_o = 8'd0;
			endcase
		end else if (iack_i) begin
			dout_o = irq_vec;
		end
	end

endmodule

// ==== hw/io_fifo.sv ====
// ================================================
// synchronous byte fifo with full and avail flags
// ================================================
module io_fifo import mfp_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       push_i,
	input  logic [7:0] din_i,
	input  logic       pop_i,
	output logic [7:0] dout_o,
	output logic       full_o,
	output logic       avail_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0]    mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// occupancy, one bit wider than the pointers
	logic [AW:0]   cnt;
	logic          do_push;
	logic          do_pop;

	assign full_o  = (cnt == FIFO_DEPTH[AW:0]);
	assign avail_o = (cnt != '0);

	// push into full and pop from empty are dropped here
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && avail_o;

	// head of the queue, no read latency
	assign dout_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			// pointers wrap naturally at the power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			if (do_push && !do_pop)
				cnt <= cnt + 1'b1;
			else if (do_pop && !do_push)
				cnt <= cnt - 1'b1;
		end
	end

endmodule

// ==== hw/mfp_timer.sv ====
// ================================================
// 8-bit down counting timer, delay and event modes
// ================================================
module mfp_timer import mfp_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       ctrl_we_i,
	input  logic       dat_we_i,
	input  logic [7:0] din_i,
	input  logic       t_i,
	output logic [7:0] dat_o,
	output logic [3:0] ctrl_o,
	output logic       done_o
);

	logic [3:0] ctrl;
	logic [7:0] reload;
	logic [7:0] count;
	logic [7:0] presc;
	logic [7:0] div;
	// timer input sampled twice for edge detection
	logic       t_q;
	logic       t_qq;
	logic       delay_mode;
	logic       event_mode;
	logic       stopped;
	logic       tick;
	logic       cnt_en;

	// modes 1..7 divide the system clock, mode 8 counts t_i edges
	assign delay_mode = (ctrl[3] == 1'b0) && (ctrl[2:0] != 3'd0);
	assign event_mode = (ctrl == 4'd8);
	// anything else leaves the counter alone
	assign stopped    = !delay_mode && !event_mode;

	assign div    = prescale_div(ctrl[2:0]);
	assign tick   = delay_mode && (presc == div - 8'd1);
	assign cnt_en = tick || (event_mode && t_q && !t_qq);

	assign dat_o  = count;
	assign ctrl_o = ctrl;

	// reload value, written by the cpu only
	always_ff @(posedge clk) begin
		if (dat_we_i)
			reload <= din_i;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl   <= 4'd0;
			count  <= 8'd0;
			presc  <= 8'd0;
			t_q    <= 1'b0;
			t_qq   <= 1'b0;
			done_o <= 1'b0;
		end else begin
			t_q    <= t_i;
			t_qq   <= t_q;
			done_o <= 1'b0;

			// new mode restarts the prescaler
			if (ctrl_we_i) begin
				ctrl  <= din_i[3:0];
				presc <= 8'd0;
			end else if (tick || !delay_mode) begin
				presc <= 8'd0;
			end else begin
				presc <= presc + 8'd1;
			end

			// a stopped counter follows data writes directly
			if (dat_we_i && stopped) begin
				count <= din_i;
			end else if (cnt_en) begin
				if (count == 8'd1) begin
					count  <= reload;
					done_o <= 1'b1;
				end else begin
					// 0 wraps to 255, so reload 0 gives 256 counts
					count <= count - 8'd1;
				end
			end
		end
	end

endmodule

// ==== hw/mfp_prio.sv ====
// ================================================
// highest set bit of a 16-bit interrupt map
// ================================================
module mfp_prio (
	input  logic [15:0] map_i,
	output logic [3:0]  num_o,
	output logic        any_o
);

	assign any_o = |map_i;

	// scan upwards so the highest set bit wins
	always_comb begin
		num_o = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (map_i[i])
				num_o = i[3:0];
		end
	end

endmodule

// ==== hw/mfp_pkg.sv ====
// ================================================
// mfp register map, interrupt numbers, fifo default
// and the timer prescaler table
// ================================================
package mfp_pkg;

	// byte-wide register window, five address bits
	typedef logic [4:0] mfp_addr_t;

	localparam mfp_addr_t ADDR_GPIP = 5'h00;
	localparam mfp_addr_t ADDR_AER  = 5'h01;
	localparam mfp_addr_t ADDR_DDR  = 5'h02;
	// "a" halves hold irq 15..8, "b" halves hold irq 7..0
	localparam mfp_addr_t ADDR_IERA = 5'h03;
	localparam mfp_addr_t ADDR_IERB = 5'h04;
	localparam mfp_addr_t ADDR_IPRA = 5'h05;
	localparam mfp_addr_t ADDR_IPRB = 5'h06;
	localparam mfp_addr_t ADDR_ISRA = 5'h07;
	localparam mfp_addr_t ADDR_ISRB = 5'h08;
	localparam mfp_addr_t ADDR_IMRA = 5'h09;
	localparam mfp_addr_t ADDR_IMRB = 5'h0a;
	localparam mfp_addr_t ADDR_VR   = 5'h0b;
	localparam mfp_addr_t ADDR_TACR = 5'h0c;
	localparam mfp_addr_t ADDR_TBCR = 5'h0d;
	localparam mfp_addr_t ADDR_TADR = 5'h0f;
	localparam mfp_addr_t ADDR_TBDR = 5'h10;
	localparam mfp_addr_t ADDR_RSR  = 5'h15;
	localparam mfp_addr_t ADDR_TSR  = 5'h16;
	localparam mfp_addr_t ADDR_UDR  = 5'h17;

	// internal interrupt sources
	localparam int IRQ_TIMER_A  = 13;
	localparam int IRQ_TIMER_B  = 8;
	localparam int IRQ_TX_EMPTY = 10;
	localparam int IRQ_RX_FULL  = 12;

	// interrupt bit per gpio pin, entry 0 is pin 0
	localparam logic [7:0][3:0] GPIP_IRQ_MAP = {
		4'd15, 4'd14, 4'd7, 4'd6, 4'd3, 4'd2, 4'd1, 4'd0
	};

	// default depth of both byte fifos, must be a power of two
	localparam int FIFO_DEPTH_DEF = 4;

	// delay mode divider, mode 0 means stopped
	function automatic logic [7:0] prescale_div(input logic [2:0] mode);
		case (mode)
			3'd1: prescale_div = 8'd4;
			3'd2: prescale_div = 8'd10;
			3'd3: prescale_div = 8'd16;
			3'd4: prescale_div = 8'd50;
			3'd5: prescale_div = 8'd64;
			3'd6: prescale_div = 8'd100;
			3'd7: prescale_div = 8'd200;
			default: prescale_div = 8'd0;
		endcase
	endfunction

endpackage
